// File: hdl/graph_geometry_pkg.sv
package graph_geometry_pkg;

    // Detectors delivered per measurement round
    localparam int GRID_WIDTH_X = 4;

    // Rounds kept in the history buffer by default, must be at least 2
    localparam int GRID_WIDTH_U_DEFAULT = 3;

    // Width of the fill counter, enough for depths up to 15
    localparam int ROUND_COUNT_WIDTH = 4;

    // One round of detector bits, bit n is detector n
    typedef logic [GRID_WIDTH_X-1:0] detector_round_t;

    // Number of rounds currently held in the buffer
    typedef logic [ROUND_COUNT_WIDTH-1:0] round_count_t;

endpackage

// File: hdl/correction_format_pkg.sv
package correction_format_pkg;

    // One spatial link between each pair of neighbouring detectors
    localparam int SPATIAL_COUNT = graph_geometry_pkg::GRID_WIDTH_X - 1;

    // One temporal link per detector position, round 0 to round 1
    localparam int TEMPORAL_COUNT = graph_geometry_pkg::GRID_WIDTH_X;

    localparam int CORRECTION_COUNT = SPATIAL_COUNT + TEMPORAL_COUNT;

    // Spatial block first, temporal block above it
    localparam int SPATIAL_OFFSET = 0;
    localparam int TEMPORAL_OFFSET = SPATIAL_OFFSET + SPATIAL_COUNT;

    typedef logic [SPATIAL_COUNT-1:0] spatial_flags_t;
    typedef logic [TEMPORAL_COUNT-1:0] temporal_flags_t;
    typedef logic [CORRECTION_COUNT-1:0] correction_t;

endpackage

// File: hdl/syndrome_round_buffer.sv
`timescale 1ns/1ps

module syndrome_round_buffer #(
    parameter int GRID_WIDTH_U = graph_geometry_pkg::GRID_WIDTH_U_DEFAULT
) (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                measurements_valid_i,
    input  graph_geometry_pkg::detector_round_t measurements_i,
    output graph_geometry_pkg::detector_round_t round0_o,
    output graph_geometry_pkg::detector_round_t round1_o,
    output logic                                shift_valid_o,
    output logic                                history_full_o
);

    localparam graph_geometry_pkg::round_count_t FULL_COUNT =
        graph_geometry_pkg::round_count_t'(GRID_WIDTH_U);
    localparam graph_geometry_pkg::round_count_t LAST_FILL_COUNT =
        graph_geometry_pkg::round_count_t'(GRID_WIDTH_U - 1);

    // Index 0 is the oldest round, GRID_WIDTH_U-1 the newest
    graph_geometry_pkg::detector_round_t rounds [GRID_WIDTH_U];
    graph_geometry_pkg::round_count_t    fill_count;

    // Round stack, every entry moves one step toward round 0 per strobe
    always_ff @(posedge clk) begin
        if (measurements_valid_i) begin
            for (int k = 0; k < GRID_WIDTH_U - 1; k++) begin
                rounds[k] <= rounds[k+1];
            end
            rounds[GRID_WIDTH_U-1] <= measurements_i; // Newest round enters at the top
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fill_count    <= '0;
            shift_valid_o <= 1'b0;
        end else begin
            if (measurements_valid_i && (fill_count != FULL_COUNT)) begin
                fill_count <= fill_count + 1'b1; // Saturates at full depth
            end
            // Pulse once this strobe completes or follows a full history
            shift_valid_o <= measurements_valid_i && (fill_count >= LAST_FILL_COUNT);
        end
    end

    assign round0_o       = rounds[0];
    assign round1_o       = rounds[1];
    assign history_full_o = (fill_count == FULL_COUNT);

endmodule

// File: hdl/spatial_link_array.sv
`timescale 1ns/1ps

module spatial_link_array (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   round_valid_i,
    input  graph_geometry_pkg::detector_round_t    round0_i,
    output correction_format_pkg::spatial_flags_t  spatial_flags_o,
    output logic                                   spatial_valid_o
);

    correction_format_pkg::spatial_flags_t pair_defects;

    // Link n joins detectors n and n+1 of the oldest round
    always_comb begin
        for (int n = 0; n < correction_format_pkg::SPATIAL_COUNT; n++) begin
            pair_defects[n] = round0_i[n] & round0_i[n+1];
        end
    end

    always_ff @(posedge clk) begin
        if (round_valid_i) begin
            spatial_flags_o <= pair_defects;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            spatial_valid_o <= 1'b0;
        end else begin
            spatial_valid_o <= round_valid_i; // One cycle behind the flags' source
        end
    end

endmodule

// File: hdl/temporal_link_array.sv
`timescale 1ns/1ps

module temporal_link_array (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   round_valid_i,
    input  graph_geometry_pkg::detector_round_t    round0_i,
    input  graph_geometry_pkg::detector_round_t    round1_i,
    output correction_format_pkg::temporal_flags_t temporal_flags_o,
    output logic                                   temporal_valid_o
);

    correction_format_pkg::temporal_flags_t repeat_defects;

    // Same detector flagged in two consecutive rounds
    always_comb begin
        for (int n = 0; n < correction_format_pkg::TEMPORAL_COUNT; n++) begin
            repeat_defects[n] = round0_i[n] & round1_i[n];
        end
    end

    always_ff @(posedge clk) begin
        if (round_valid_i) begin
            temporal_flags_o <= repeat_defects;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            temporal_valid_o <= 1'b0;
        end else begin
            temporal_valid_o <= round_valid_i; // Lockstep with the spatial array
        end
    end

endmodule

// File: hdl/correction_assembler.sv
`timescale 1ns/1ps

module correction_assembler (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   spatial_valid_i,
    input  correction_format_pkg::spatial_flags_t  spatial_flags_i,
    input  correction_format_pkg::temporal_flags_t temporal_flags_i,
    output correction_format_pkg::correction_t     correction_o,
    output logic                                   correction_valid_o
);

    correction_format_pkg::correction_t correction_next;

    // Place each link block at its offset in the correction vector
    always_comb begin
        correction_next = '0;
        correction_next[correction_format_pkg::SPATIAL_OFFSET +:
                        correction_format_pkg::SPATIAL_COUNT] = spatial_flags_i;
        correction_next[correction_format_pkg::TEMPORAL_OFFSET +:
                        correction_format_pkg::TEMPORAL_COUNT] = temporal_flags_i;
    end

    // Temporal flags arrive with the same pulse, so one valid is enough
    always_ff @(posedge clk) begin
        if (rst_i) begin
            correction_o       <= '0;
            correction_valid_o <= 1'b0;
        end else begin
            if (spatial_valid_i) begin
                correction_o <= correction_next; // Held until the next pulse
            end
            correction_valid_o <= spatial_valid_i;
        end
    end

endmodule

// File: hdl/decoding_graph_top.sv
`timescale 1ns/1ps

module decoding_graph_top #(
    parameter int GRID_WIDTH_U = graph_geometry_pkg::GRID_WIDTH_U_DEFAULT
) (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                measurements_valid_i,
    input  graph_geometry_pkg::detector_round_t measurements_i,
    output correction_format_pkg::correction_t  correction_o,
    output logic                                correction_valid_o,
    output logic                                history_full_o
);

    graph_geometry_pkg::detector_round_t    round0;
    graph_geometry_pkg::detector_round_t    round1;
    logic                                   shift_valid;
    correction_format_pkg::spatial_flags_t  spatial_flags;
    logic                                   spatial_valid;
    correction_format_pkg::temporal_flags_t temporal_flags;

    syndrome_round_buffer #(
        .GRID_WIDTH_U(GRID_WIDTH_U)
    ) u_round_buffer (
        .clk                  (clk),
        .rst_i                (rst_i),
        .measurements_valid_i (measurements_valid_i),
        .measurements_i       (measurements_i),
        .round0_o             (round0),
        .round1_o             (round1),
        .shift_valid_o        (shift_valid),
        .history_full_o       (history_full_o)
    );

    spatial_link_array u_spatial_links (
        .clk             (clk),
        .rst_i           (rst_i),
        .round_valid_i   (shift_valid),
        .round0_i        (round0),
        .spatial_flags_o (spatial_flags),
        .spatial_valid_o (spatial_valid)
    );

    // Temporal valid always coincides with spatial_valid
    temporal_link_array u_temporal_links (
        .clk              (clk),
        .rst_i            (rst_i),
        .round_valid_i    (shift_valid),
        .round0_i         (round0),
        .round1_i         (round1),
        .temporal_flags_o (temporal_flags),
        .temporal_valid_o ()
    );

    correction_assembler u_assembler (
        .clk                (clk),
        .rst_i              (rst_i),
        .spatial_valid_i    (spatial_valid),
        .spatial_flags_i    (spatial_flags),
        .temporal_flags_i   (temporal_flags),
        .correction_o       (correction_o),
        .correction_valid_o (correction_valid_o)
    );

endmodule

// File: tb/decoding_graph_checker.sv
`timescale 1ns/1ps

module decoding_graph_checker (
    input logic                               clk,
    input logic                               rst_i,
    input logic                               measurements_valid_i,
    input correction_format_pkg::correction_t correction_o,
    input logic                               correction_valid_o
);

    // Buffer, link arrays and assembler add one cycle each
    property valid_follows_strobe;
        @(posedge clk) disable iff (rst_i)
            correction_valid_o |-> $past(measurements_valid_i, 3);
    endproperty

    property quiet_around_reset;
        @(posedge clk) ($past(rst_i) || $past(rst_i, 2)) |-> !correction_valid_o;
    endproperty

    property known_correction;
        @(posedge clk) disable iff (rst_i)
            correction_valid_o |-> !$isunknown(correction_o);
    endproperty

    assert property (valid_follows_strobe)
        else $error("correction_valid_o without a strobe three cycles earlier");
    assert property (quiet_around_reset)
        else $error("correction_valid_o high during or right after reset");
    assert property (known_correction)
        else $error("correction_o has unknown bits while valid");

endmodule

bind decoding_graph_top decoding_graph_checker u_checker (
    .clk                  (clk),
    .rst_i                (rst_i),
    .measurements_valid_i (measurements_valid_i),
    .correction_o         (correction_o),
    .correction_valid_o   (correction_valid_o)
);

// File: tb/tb_decoding_graph.sv
`timescale 1ns/1ps

module tb_decoding_graph;

    localparam string GOLDEN_FILE   = "tb/decoding_graph_golden.txt";
    localparam int    HISTORY_DEPTH = graph_geometry_pkg::GRID_WIDTH_U_DEFAULT;
    localparam int    LATENCY       = 3; // Strobe edge to correction_valid_o

    logic                                clk;
    logic                                rst_i;
    logic                                measurements_valid_i;
    graph_geometry_pkg::detector_round_t measurements_i;
    correction_format_pkg::correction_t  correction_o;
    logic                                correction_valid_o;
    logic                                history_full_o;

    // Golden stimulus, one entry per file line
    graph_geometry_pkg::detector_round_t stim_rounds [$];
    logic                                stim_valid [$];
    correction_format_pkg::correction_t  stim_corrections [$];

    // Corrections in flight and the cycle each one is due
    correction_format_pkg::correction_t  expected_q [$];
    int                                  due_q [$];

    int cycle;
    int strobes_taken;
    int checked_count;
    int valid_lines;
    int pulse_count = 0;
    int timeout_cycles = 0;
    int watchdog_count = 0;

    decoding_graph_top u_dut (
        .clk                  (clk),
        .rst_i                (rst_i),
        .measurements_valid_i (measurements_valid_i),
        .measurements_i       (measurements_i),
        .correction_o         (correction_o),
        .correction_valid_o   (correction_valid_o),
        .history_full_o       (history_full_o)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    always @(posedge clk) begin
        watchdog_count = watchdog_count + 1;
        if (timeout_cycles > 0 && watchdog_count > timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            abort_run("timeout");
        end
    end

    // Every correction_valid_o pulse, reset windows included
    always @(negedge clk) begin
        if (correction_valid_o === 1'b1) begin
            pulse_count = pulse_count + 1;
        end
    end

    task automatic check_correction(input correction_format_pkg::correction_t actual,
                                    input correction_format_pkg::correction_t expected,
                                    input int index);
        if (actual !== expected) begin
            $display("FAIL %0t: correction %0d is %h, expected %h",
                     $time, index, actual, expected);
            abort_run("correction mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, name, actual, expected);
            abort_run("flag mismatch");
        end
    endtask

    task automatic load_golden();
        int              fd;
        int              fields;
        logic [8*80-1:0] text;
        logic [31:0]     meas_word;
        logic [31:0]     valid_word;
        logic [31:0]     corr_word;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN_FILE);
            abort_run("no golden file");
        end
        valid_lines = 0;
        while (!$feof(fd)) begin
            text = '0;
            void'($fgets(text, fd));
            fields = $sscanf(text, "%h %h %h", meas_word, valid_word, corr_word);
            if (fields == 3) begin // Header and blank lines parse to fewer fields
                stim_rounds.push_back(graph_geometry_pkg::detector_round_t'(meas_word));
                stim_valid.push_back(valid_word != 0);
                stim_corrections.push_back(correction_format_pkg::correction_t'(corr_word));
                if (valid_word != 0) begin
                    valid_lines++;
                end
            end
        end
        $fclose(fd);
        if (stim_rounds.size() == 0) begin
            $display("The golden file %s holds no rounds", GOLDEN_FILE);
            abort_run("empty golden file");
        end
    endtask

    // Outputs are checked on the falling edge, before new inputs are driven
    task automatic next_cycle();
        logic due_now;
        @(negedge clk);
        cycle++;
        due_now = (due_q.size() > 0) && (due_q[0] == cycle);
        check_flag("correction_valid_o", correction_valid_o, due_now);
        check_flag("history_full_o", history_full_o, strobes_taken >= HISTORY_DEPTH);
        if (due_now) begin
            void'(due_q.pop_front());
            check_correction(correction_o, expected_q.pop_front(), checked_count);
            checked_count++;
        end
    endtask

    task automatic apply_reset();
        rst_i                = 1'b1;
        measurements_valid_i = 1'b0;
        repeat (3) begin
            @(negedge clk);
            cycle++;
        end
        rst_i         = 1'b0;
        strobes_taken = 0; // Fill count is back to zero
    endtask

    task automatic drive_round(input int index);
        measurements_valid_i = 1'b1;
        measurements_i       = stim_rounds[index];
        strobes_taken++;
        if (stim_valid[index]) begin
            expected_q.push_back(stim_corrections[index]);
            due_q.push_back(cycle + LATENCY);
        end
        next_cycle();
        measurements_valid_i = 1'b0;
    endtask

    task automatic run_sequence(input bit random_gaps);
        int gap;
        for (int i = 0; i < stim_rounds.size(); i++) begin
            drive_round(i);
            if (random_gaps) begin
                gap = $urandom_range(3);
                repeat (gap) begin
                    // Idle data must be ignored by the buffer
                    measurements_i = graph_geometry_pkg::detector_round_t'($urandom_range(15));
                    next_cycle();
                end
            end
        end
        while (due_q.size() > 0) begin
            next_cycle();
        end
        repeat (LATENCY) next_cycle(); // No stray pulses after the last one
    endtask

    initial begin
        clk                  = 1'b0;
        rst_i                = 1'b1;
        measurements_valid_i = 1'b0;
        measurements_i       = '0;
        cycle                = 0;
        strobes_taken        = 0;
        checked_count        = 0;
        void'($urandom(61));
        load_golden();
        timeout_cycles = stim_rounds.size() * 6 + 50;

        apply_reset();
        run_sequence(1'b0); // Back to back strobes
        apply_reset();
        run_sequence(1'b1); // Same rounds with random idle gaps

        if (pulse_count == 2 * valid_lines) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("correction_valid_o pulsed %0d times, expected %0d pulses",
                     pulse_count, 2 * valid_lines);
            abort_run("unexpected correction pulses");
        end
    end

endmodule

// File: tb/decoding_graph_golden.txt
# measurements(hex) valid(0/1) correction(hex)
# correction bits 2:0 are spatial links, bits 6:3 temporal links
0 0 00
0 0 00
0 1 00
6 1 00
0 1 00
0 1 02
8 1 00
8 1 00
0 1 40
f 1 00
f 1 00
0 1 7f
5 1 07
3 1 00
a 1 08
c 1 11
e 1 40
7 1 64
0 1 36
0 1 03

// File: files.f
hdl/graph_geometry_pkg.sv
hdl/correction_format_pkg.sv
hdl/syndrome_round_buffer.sv
hdl/spatial_link_array.sv
hdl/temporal_link_array.sv
hdl/correction_assembler.sv
hdl/decoding_graph_top.sv
tb/decoding_graph_checker.sv
tb/tb_decoding_graph.sv

// File: Makefile
VERILATOR       ?= verilator
BUILD_DIR       ?= build
TOP             ?= tb_decoding_graph
FILELIST        ?= files.f
VERILATOR_FLAGS ?= --binary --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR BUILD_DIR TOP FILELIST VERILATOR_FLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
